// ==== rom_load_pkg.sv ====
package rom_load_pkg;

    // one byte from the host loader
    typedef struct packed {
        logic [19:0] addr;  // file offset
        logic [7:0]  data;
    } dl_byte_t;

    // one write towards the sdram controller
    typedef struct packed {
        logic [21:0] addr;  // 16-bit word address
        logic [7:0]  data;  // copied to both lanes by the controller
        logic [1:0]  mask;  // active low, bit 0 = low byte
    } prog_word_t;

    // write strobe for the on-chip memories
    typedef struct packed {
        logic [11:0] addr;
        logic [7:0]  data;
        logic [1:0]  sel;   // bit 0 mcu, bit 1 colour prom
    } prom_wr_t;

    // region codes, file offset bits 19..16
    // main cpu code sits below snd_base
    localparam logic [3:0] snd_base  = 4'd4;   // sound then char data
    localparam logic [3:0] scr_base  = 4'd5;   // six 64k scroll slices
    localparam logic [3:0] obj_base  = 4'd11;  // four 64k object slices
    localparam logic [3:0] mcu_base  = 4'd15;  // offset bit 12 low
    localparam logic [3:0] prom_base = 4'd15;  // offset bit 12 high

    // byte masks, a zero bit enables that lane
    localparam logic [1:0] mask_lo   = 2'b10;
    localparam logic [1:0] mask_hi   = 2'b01;
    localparam logic [1:0] mask_none = 2'b11;

    // on-chip memory entries
    typedef logic [7:0] mcu_entry_t;  // mcu program byte
    typedef logic [3:0] col_entry_t;  // colour prom, low nibble only

endpackage

// ==== rom_download_rx.sv ====
`timescale 1ns/1ps

module rom_download_rx (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  downloading,  // frames the whole transfer
    input  logic                  dl_req,
    input  rom_load_pkg::dl_byte_t dl_byte,
    output logic                  dl_ack,
    input  logic                  busy,         // sdram port still holds a word
    output logic                  wr_valid,
    output rom_load_pkg::dl_byte_t wr_byte
);

    typedef enum logic {
        rx_idle,  // waiting for a request
        rx_hold   // ack high, waiting for req to drop
    } rx_state_t;

    rx_state_t state;

    // accept only with a free downstream path
    logic take;
    assign take = (state == rx_idle) && downloading && dl_req && !busy;

    always_ff @(posedge clk) begin
        if (take) begin
            wr_byte <= dl_byte;  // host keeps it stable while req is high
        end
        if (rst) begin
            state    <= rx_idle;
            dl_ack   <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= 1'b0;  // single cycle strobe
            case (state)
                rx_idle: begin
                    if (take) begin
                        wr_valid <= 1'b1;
                        dl_ack   <= 1'b1;  // same cycle as wr_valid
                        state    <= rx_hold;
                    end
                end
                rx_hold: begin
                    // return to zero
                    if (!dl_req) begin
                        dl_ack <= 1'b0;
                        state  <= rx_idle;
                    end
                end
                default: begin
                    dl_ack <= 1'b0;
                    state  <= rx_idle;
                end
            endcase
        end
    end

    // ack answers a req seen on the edge before, host may already have dropped it
    ack_needs_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(dl_ack) |-> $past(dl_req)
    );

endmodule

// ==== rom_addr_map.sv ====
`timescale 1ns/1ps

module rom_addr_map (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_valid,
    input  rom_load_pkg::dl_byte_t  wr_byte,
    output logic                    prog_valid,
    output rom_load_pkg::prog_word_t prog,
    output rom_load_pkg::prom_wr_t  prom_wr
);

    logic [19:0] off;
    logic [3:0]  c;       // region code
    logic [3:0]  s;       // scroll slice
    logic [3:0]  grp;     // scroll group, s mod 3
    logic [3:0]  o;       // object slice
    logic        to_sdram;
    logic [1:0]  sel_nx;
    rom_load_pkg::prog_word_t prog_nx;

    assign off = wr_byte.addr;
    assign c   = off[19:16];
    assign s   = c - rom_load_pkg::scr_base;
    assign o   = c - rom_load_pkg::obj_base;
    assign grp = (s >= 4'd3) ? s - 4'd3 : s;  // s only spans 0..5

    always_comb begin
        prog_nx.data = wr_byte.data;
        prog_nx.addr = {2'b00, off};  // not used for code 15
        prog_nx.mask = rom_load_pkg::mask_none;
        to_sdram     = 1'b1;
        sel_nx       = 2'b00;
        if (c < rom_load_pkg::snd_base) begin
            // main code, bit 17 picks the byte lane
            prog_nx.addr = {5'd0, off[16:0]};
            prog_nx.mask = off[17] ? rom_load_pkg::mask_lo : rom_load_pkg::mask_hi;
        end else if (c == rom_load_pkg::snd_base) begin
            // sound and char, packed two bytes per word
            prog_nx.addr = {3'd0, c, off[15:1]};
            prog_nx.mask = off[0] ? rom_load_pkg::mask_lo : rom_load_pkg::mask_hi;
        end else if (c < rom_load_pkg::obj_base) begin
            // scroll, second half of the slices fills the low lane
            prog_nx.addr = {2'd0, rom_load_pkg::scr_base + grp, off[15:0]};
            prog_nx.mask = (s >= 4'd3) ? rom_load_pkg::mask_lo : rom_load_pkg::mask_hi;
        end else if (c < rom_load_pkg::mcu_base) begin
            // objects, bit 5 moved down next to bit 0 for the fetch order
            prog_nx.addr = {2'd0, rom_load_pkg::obj_base + {3'd0, o[0]},
                            off[15:6], off[4:1], off[5], off[0]};
            prog_nx.mask = o[1] ? rom_load_pkg::mask_lo : rom_load_pkg::mask_hi;
        end else begin
            // mcu or colour prom, kept on chip
            to_sdram  = 1'b0;
            sel_nx[0] = (c == rom_load_pkg::mcu_base) && !off[12];
            sel_nx[1] = (c == rom_load_pkg::prom_base) && off[12];
        end
    end

    always_ff @(posedge clk) begin
        // payload, qualified by the strobes
        prog         <= prog_nx;
        prom_wr.addr <= off[11:0];
        prom_wr.data <= wr_byte.data;
        if (rst) begin
            prog_valid  <= 1'b0;
            prom_wr.sel <= 2'b00;
        end else begin
            prog_valid  <= wr_valid && to_sdram;
            prom_wr.sel <= wr_valid ? sel_nx : 2'b00;
        end
    end

    // a byte lands in exactly one place
    one_target: assert property (
        @(posedge clk) disable iff (rst)
        !(prog_valid && (prom_wr.sel != 2'b00))
    );

endmodule

// ==== sdram_prog_port.sv ====
`timescale 1ns/1ps

module sdram_prog_port (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     prog_valid,
    input  rom_load_pkg::prog_word_t prog,
    output logic                     busy,
    output logic                     sd_req,
    output rom_load_pkg::prog_word_t sd_word,
    input  logic                     sd_ack
);

    typedef enum logic [1:0] {
        sp_idle,  // empty
        sp_req,   // req high, waiting for ack
        sp_rel    // req low, waiting for ack to drop
    } sp_state_t;

    sp_state_t state;

    // covers the strobe cycle too, before the word is registered
    assign busy = prog_valid || (state != sp_idle);

    always_ff @(posedge clk) begin
        if (prog_valid && state == sp_idle) begin
            sd_word <= prog;  // held until the next word
        end
        if (rst) begin
            state  <= sp_idle;
            sd_req <= 1'b0;
        end else begin
            case (state)
                sp_idle: begin
                    if (prog_valid) begin
                        sd_req <= 1'b1;  // one cycle after prog_valid
                        state  <= sp_req;
                    end
                end
                sp_req: begin
                    if (sd_ack) begin
                        sd_req <= 1'b0;
                        state  <= sp_rel;
                    end
                end
                sp_rel: begin
                    // controller finishing its return to zero
                    if (!sd_ack) begin
                        state <= sp_idle;
                    end
                end
                default: begin
                    sd_req <= 1'b0;
                    state  <= sp_idle;
                end
            endcase
        end
    end

    // controller samples the word any time while req is high
    word_stable: assert property (
        @(posedge clk) disable iff (rst)
        (sd_req && $past(sd_req)) |-> $stable(sd_word)
    );

    // back-pressure from the receiver keeps a second word away
    no_overrun: assert property (
        @(posedge clk) disable iff (rst)
        prog_valid |-> (state == sp_idle)
    );

    // new request only after the previous ack went low
    req_after_rtz: assert property (
        @(posedge clk) disable iff (rst)
        $rose(sd_req) |-> !$past(sd_ack)
    );

endmodule

// ==== prom_bank.sv ====
`timescale 1ns/1ps

module prom_bank #(
    parameter type entry_t = logic [7:0],
    parameter int  depth   = 4096
) (
    input  logic        clk,
    input  logic        we,
    input  logic [11:0] waddr,
    input  entry_t      wdata,
    input  logic [11:0] raddr,
    output entry_t      rdata
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;

    entry_t mem [depth];

    logic [aw-1:0] wa;
    logic [aw-1:0] ra;

    // upper offset bits fold back onto the bank
    assign wa = waddr[aw-1:0];
    assign ra = raddr[aw-1:0];

    // write side, fed by the mapper
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wa] <= wdata;
        end
    end

    // read side for the game, one cycle latency
    always_ff @(posedge clk) begin
        rdata <= mem[ra];
    end

endmodule

// ==== rom_loader_top.sv ====
`timescale 1ns/1ps

module rom_loader_top #(
    parameter int mcu_depth = 4096,
    parameter int col_depth = 256
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     downloading,
    input  logic                     dl_req,
    input  rom_load_pkg::dl_byte_t   dl_byte,
    output logic                     dl_ack,
    output logic                     sd_req,
    output rom_load_pkg::prog_word_t sd_word,
    input  logic                     sd_ack,
    input  logic [11:0]              mcu_raddr,
    output rom_load_pkg::mcu_entry_t mcu_rdata,
    input  logic [11:0]              col_raddr,
    output rom_load_pkg::col_entry_t col_rdata
);

    logic                     busy;
    logic                     wr_valid;
    rom_load_pkg::dl_byte_t   wr_byte;
    logic                     prog_valid;
    rom_load_pkg::prog_word_t prog;
    rom_load_pkg::prom_wr_t   prom_wr;
    rom_load_pkg::col_entry_t col_wdata;

    assign col_wdata = prom_wr.data[3:0];  // prom keeps the low nibble

    rom_download_rx rom_download_rx_i (
        .clk(clk), .rst(rst), .downloading(downloading),
        .dl_req(dl_req), .dl_byte(dl_byte), .dl_ack(dl_ack),
        .busy(busy), .wr_valid(wr_valid), .wr_byte(wr_byte)
    );

    rom_addr_map rom_addr_map_i (
        .clk(clk), .rst(rst), .wr_valid(wr_valid), .wr_byte(wr_byte),
        .prog_valid(prog_valid), .prog(prog), .prom_wr(prom_wr)
    );

    sdram_prog_port sdram_prog_port_i (
        .clk(clk), .rst(rst), .prog_valid(prog_valid), .prog(prog), .busy(busy),
        .sd_req(sd_req), .sd_word(sd_word), .sd_ack(sd_ack)
    );

    prom_bank #(.entry_t(rom_load_pkg::mcu_entry_t), .depth(mcu_depth)) mcu_bank_i (
        .clk(clk), .we(prom_wr.sel[0]), .waddr(prom_wr.addr), .wdata(prom_wr.data),
        .raddr(mcu_raddr), .rdata(mcu_rdata)
    );

    prom_bank #(.entry_t(rom_load_pkg::col_entry_t), .depth(col_depth)) col_bank_i (
        .clk(clk), .we(prom_wr.sel[1]), .waddr(prom_wr.addr), .wdata(col_wdata),
        .raddr(col_raddr), .rdata(col_rdata)
    );

endmodule

// ==== tb_rom_loader.sv ====
`timescale 1ns/1ps

module tb_rom_loader;

    // mirrored region codes and lane masks
    localparam logic [3:0] code_snd    = 4'd4;
    localparam logic [3:0] code_scr    = 4'd5;
    localparam logic [3:0] code_obj    = 4'd11;
    localparam logic [3:0] code_onchip = 4'd15;
    localparam logic [1:0] lane_lo     = 2'b10;  // zero enables the lane
    localparam logic [1:0] lane_hi     = 2'b01;
    localparam logic [1:0] lane_none   = 2'b11;
    localparam logic [31:0] lfsr_taps  = 32'h80200003;

    localparam int n_regions = 200;
    localparam int n_obj     = 32;
    localparam int n_long    = 100;
    localparam int n_onchip  = 96;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     downloading;
    logic                     dl_req;
    rom_load_pkg::dl_byte_t   dl_byte;
    logic                     dl_ack;
    logic                     sd_req;
    rom_load_pkg::prog_word_t sd_word;
    logic                     sd_ack;
    logic [11:0]              mcu_raddr;
    rom_load_pkg::mcu_entry_t mcu_rdata;
    logic [11:0]              col_raddr;
    rom_load_pkg::col_entry_t col_rdata;

    logic [31:0] lfsr_state = 32'hdaef3e54;
    int          ack_delay_bits = 3;  // responder delay 0..7 by default
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          test_err_start = 0;
    int          words_seen = 0;
    int          words_pushed = 0;
    string       cur_test = "init";

    rom_load_pkg::prog_word_t exp_q[$];  // sdram words still to arrive
    logic [7:0] mcu_model [4096];
    bit         mcu_written [4096];
    logic [3:0] col_model [256];
    bit         col_written [256];

    rom_loader_top #(.mcu_depth(4096), .col_depth(256)) rom_loader_top_i (
        .clk(clk), .rst(rst), .downloading(downloading),
        .dl_req(dl_req), .dl_byte(dl_byte), .dl_ack(dl_ack),
        .sd_req(sd_req), .sd_word(sd_word), .sd_ack(sd_ack),
        .mcu_raddr(mcu_raddr), .mcu_rdata(mcu_rdata),
        .col_raddr(col_raddr), .col_rdata(col_rdata)
    );

    always #10 clk = ~clk;  // 20 ns period

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    // expected sdram word for one byte outside code 15
    function automatic rom_load_pkg::prog_word_t model_word(input logic [19:0] off,
                                                             input logic [7:0] d);
        rom_load_pkg::prog_word_t w;
        logic [3:0] c;
        logic [3:0] s;
        logic [3:0] o;
        c = off[19:16];
        w.data = d;
        w.addr = '0;
        w.mask = lane_none;
        if (c < code_snd) begin
            w.addr = {5'd0, off[16:0]};
            w.mask = off[17] ? lane_lo : lane_hi;
        end else if (c == code_snd) begin
            w.addr = {3'd0, c, off[15:1]};
            w.mask = off[0] ? lane_lo : lane_hi;
        end else if (c < code_obj) begin
            s = c - code_scr;
            w.addr = {2'd0, 4'((s % 4'd3) + 4'd5), off[15:0]};
            w.mask = (s > 4'd2) ? lane_lo : lane_hi;
        end else begin
            o = c - code_obj;
            // bit 5 drops to position 1, bits 4..1 shift up
            w.addr = {2'd0, (o[0] ? 4'd12 : 4'd11), off[15:6], off[4:1], off[5], off[0]};
            w.mask = o[1] ? lane_lo : lane_hi;
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic report_fault(input string what);
        errors++;
        $display("%s: %s", cur_test, what);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_err_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        $display("test %s done, %0d errors", cur_test, errors - test_err_start);
    endtask

    task automatic wait_dl_ack(input logic level);
        do begin
            @(posedge clk);
            #1;
        end while (dl_ack !== level);
    endtask

    // one host byte, model updated before the handshake
    task automatic send_byte(input logic [19:0] off, input logic [7:0] d);
        if (off[19:16] == code_onchip) begin
            if (!off[12]) begin
                mcu_model[off[11:0]] = d;
                mcu_written[off[11:0]] = 1'b1;
            end else begin
                col_model[off[7:0]] = d[3:0];  // bank folds onto 8 bits
                col_written[off[7:0]] = 1'b1;
            end
        end else begin
            exp_q.push_back(model_word(off, d));
            words_pushed++;
        end
        dl_byte = {off, d};
        dl_req = 1'b1;
        wait_dl_ack(1'b1);
        dl_req = 1'b0;
        wait_dl_ack(1'b0);
    endtask

    task automatic drain_sdram();
        do begin
            @(posedge clk);
            #1;
        end while (exp_q.size() != 0 || sd_req || sd_ack);
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic read_banks();
        int i;
        for (i = 0; i < 4096; i++) begin
            if (mcu_written[i]) begin
                mcu_raddr = 12'(i);
                @(posedge clk);
                #1;
                check_value({cur_test, " mcu"}, {24'd0, mcu_model[i]}, {24'd0, mcu_rdata});
            end
        end
        for (i = 0; i < 256; i++) begin
            if (col_written[i]) begin
                col_raddr = 12'(i);
                @(posedge clk);
                #1;
                check_value({cur_test, " col"}, {28'd0, col_model[i]}, {28'd0, col_rdata});
            end
        end
    endtask

    // sdram controller stand-in, acts 2 ns after the edge to stay clear of the host
    initial begin : sdram_responder
        rom_load_pkg::prog_word_t held;
        rom_load_pkg::prog_word_t exp_word;
        int delay;
        sd_ack = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (sd_req) begin
                held = sd_word;
                delay = int'(rand_bits(ack_delay_bits));
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                check_value({cur_test, " word held"}, held, sd_word);
                sd_ack = 1'b1;
                words_seen++;
                if (exp_q.size() == 0) begin
                    report_fault("SDRAM write arrived with no byte left to deliver");
                end else begin
                    exp_word = exp_q.pop_front();
                    check_value(cur_test, exp_word, sd_word);
                end
                do begin
                    @(posedge clk);
                    #2;
                end while (sd_req);
                sd_ack = 1'b0;  // return to zero
            end
        end
    end

    // four-phase order on both ports, sampled mid-cycle
    initial begin : handshake_monitor
        logic prev_dl_req;
        logic prev_dl_ack;
        logic prev_sd_req;
        logic prev_sd_ack;
        prev_dl_req = 1'b0;
        prev_dl_ack = 1'b0;
        prev_sd_req = 1'b0;
        prev_sd_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (dl_ack && !prev_dl_ack && !prev_dl_req)
                    report_fault("dl_ack rose without a pending dl_req");
                if (!dl_ack && prev_dl_ack && prev_dl_req)
                    report_fault("dl_ack fell before the host released dl_req");
                if (sd_req && !prev_sd_req && prev_sd_ack)
                    report_fault("sd_req rose again before sd_ack returned low");
                if (!sd_req && prev_sd_req && !prev_sd_ack)
                    report_fault("sd_req dropped without an sd_ack");
            end
            prev_dl_req = dl_req;
            prev_dl_ack = dl_ack;
            prev_sd_req = sd_req;
            prev_sd_ack = sd_ack;
        end
    end

    // budget from the byte counts, long delays and readback
    initial begin : watchdog
        int limit;
        limit = (n_regions + n_obj + n_long + n_onchip) * 40 + n_long * 32
                + 2 * (n_long + n_onchip) + 500;
        repeat (limit) @(posedge clk);
        $display("timeout: the download did not finish within %0d cycles", limit);
        $display("sim failed");
        $finish;
    end

    initial begin : main_seq
        logic [19:0] off;
        logic [3:0]  c;
        int          i;
        int          words_start;
        rst = 1'b1;
        downloading = 1'b0;
        dl_req = 1'b0;
        dl_byte = '0;
        mcu_raddr = '0;
        col_raddr = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        downloading = 1'b1;

        // 1: idle after reset
        begin_test("reset_idle");
        repeat (10) begin
            @(posedge clk);
            #1;
            check_value({cur_test, " dl_ack"}, 32'd0, {31'd0, dl_ack});
            check_value({cur_test, " sd_req"}, 32'd0, {31'd0, sd_req});
        end
        end_test();

        // 2: random bytes over the four sdram regions
        begin_test("sdram_regions");
        words_start = words_seen;
        words_pushed = 0;
        for (i = 0; i < n_regions; i++) begin
            c = 4'(rand_bits(4));
            if (c == code_onchip) c = {2'b00, 2'(rand_bits(2))};  // fold into main
            off = {c, 16'(rand_bits(16))};
            send_byte(off, 8'(rand_bits(8)));
        end
        drain_sdram();
        check_value({cur_test, " count"}, 32'(words_pushed), 32'(words_seen - words_start));
        end_test();

        // 3: object bits 5 and 4..1 swept
        begin_test("obj_permute");
        words_start = words_seen;
        words_pushed = 0;
        off = {4'(code_obj + 4'(rand_bits(2))), 16'(rand_bits(16))};
        for (i = 0; i < n_obj; i++) begin
            off[5]   = i[4];
            off[4:1] = i[3:0];
            send_byte(off, 8'(rand_bits(8)));
        end
        drain_sdram();
        check_value({cur_test, " count"}, 32'(words_pushed), 32'(words_seen - words_start));
        end_test();

        // 5: all regions with acks up to 31 cycles late
        begin_test("long_ack");
        ack_delay_bits = 5;
        words_start = words_seen;
        words_pushed = 0;
        for (i = 0; i < n_long; i++) begin
            off = 20'(rand_bits(20));
            send_byte(off, 8'(rand_bits(8)));
        end
        drain_sdram();
        check_value({cur_test, " count"}, 32'(words_pushed), 32'(words_seen - words_start));
        ack_delay_bits = 3;
        end_test();

        // 4: code 15 only, then read both banks back
        begin_test("onchip_banks");
        words_start = words_seen;
        for (i = 0; i < n_onchip; i++) begin
            off = {code_onchip, 16'(rand_bits(16))};
            send_byte(off, 8'(rand_bits(8)));
        end
        drain_sdram();
        check_value({cur_test, " no sd_req"}, 32'(words_start), 32'(words_seen));
        downloading = 1'b0;
        read_banks();
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
rom_load_pkg.sv
rom_download_rx.sv
rom_addr_map.sv
sdram_prog_port.sv
prom_bank.sv
rom_loader_top.sv
tb_rom_loader.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ROM loader testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rom_loader \
    -f project.f \
    -o tb_rom_loader_sim

./obj_dir/tb_rom_loader_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
    echo "result: PASS"
else
    echo "result: FAIL"
    exit 1
fi
